//--- flist.f
+incdir+include
hdl/proc_pkg.sv
hdl/proc_decode.sv
hdl/proc_regfile.sv
hdl/proc_exec.sv
hdl/proc_bypass_queue.sv
hdl/proc_ctrl.sv
hdl/proc_top.sv
verif/proc_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f flist.f --top-module proc_tb -o proc_tb_sim
	./obj_dir/proc_tb_sim | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module proc_tb

clean:
	rm -rf obj_dir sim.log

//--- verif/proc_tb.sv
// ------------------------------------------------
// Runs one generated program twice, stall free and
// under random stalls; memory is 4 KB word indexed
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_tb;

  logic clk = 1'b0;
  logic reset;
  proc_pkg::mem_req_t    imem_req_msg, dmem_req_msg;
  logic                  imem_req_val, imem_req_rdy, dmem_req_val, dmem_req_rdy;
  proc_pkg::mem_resp_t   imem_resp_msg, dmem_resp_msg;
  logic                  imem_resp_val, imem_resp_rdy, dmem_resp_val, dmem_resp_rdy;
  logic [`PROC_XLEN-1:0] m2p_msg, p2m_msg;
  logic                  m2p_val, m2p_rdy, p2m_val, p2m_rdy;

  logic [31:0] mem [1024];
  logic [31:0] prog[$], src_q[$], exp_q[$], got0_q[$], got1_q[$];
  proc_pkg::mem_req_t exp_dmem_q[$];
  logic [31:0] lfsr_state = 32'h4e0598b8;
  logic        stall_en = 1'b0;
  int          run_id = 0;
  int          src_idx, out_idx, dmem_idx, err_cnt = 0, timeout_cnt = 0;
  logic        first_seen, imem_busy, dmem_busy;
  logic [31:0] imem_addr, dmem_data;
  int          imem_delay, dmem_delay;

  proc_top i_proc_top (
    .clk, .reset,
    .imem_req_msg_o (imem_req_msg), .imem_req_val_o (imem_req_val),
    .imem_req_rdy_i (imem_req_rdy), .imem_resp_msg_i (imem_resp_msg),
    .imem_resp_val_i (imem_resp_val), .imem_resp_rdy_o (imem_resp_rdy),
    .dmem_req_msg_o (dmem_req_msg), .dmem_req_val_o (dmem_req_val),
    .dmem_req_rdy_i (dmem_req_rdy), .dmem_resp_msg_i (dmem_resp_msg),
    .dmem_resp_val_i (dmem_resp_val), .dmem_resp_rdy_o (dmem_resp_rdy),
    .mngr2proc_msg_i (m2p_msg), .mngr2proc_val_i (m2p_val), .mngr2proc_rdy_o (m2p_rdy),
    .proc2mngr_msg_o (p2m_msg), .proc2mngr_val_o (p2m_val), .proc2mngr_rdy_i (p2m_rdy)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] ref_alu(input proc_pkg::alu_op_t op,
                                          input logic [31:0] a, input logic [31:0] b);
    case (op)
      proc_pkg::ALU_SUB: return a - b;
      proc_pkg::ALU_AND: return a & b;
      proc_pkg::ALU_OR:  return a | b;
      proc_pkg::ALU_XOR: return a ^ b;
      default:           return a + b;
    endcase
  endfunction

  // ------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------
  function automatic logic [31:0] enc_rop(input proc_pkg::alu_op_t op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0] f3;
    case (op)
      proc_pkg::ALU_AND: f3 = `PROC_F3_AND;
      proc_pkg::ALU_OR:  f3 = `PROC_F3_OR;
      proc_pkg::ALU_XOR: f3 = `PROC_F3_XOR;
      default:           f3 = `PROC_F3_ADD;
    endcase
    return {(op == proc_pkg::ALU_SUB) ? `PROC_F7_SUB : `PROC_F7_BASE,
            rs2, rs1, f3, rd, `PROC_OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, `PROC_F3_SW, imm[4:0], `PROC_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_bne(input logic [12:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, `PROC_F3_BNE, imm[4:1], imm[11], `PROC_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_csrr(input logic [4:0] rd);
    return enc_i(`PROC_CSR_MNGR2PROC, 5'd0, `PROC_F3_CSRR, rd, `PROC_OP_SYSTEM);
  endfunction

  function automatic logic [31:0] enc_csrw(input logic [4:0] rs1);
    return enc_i(`PROC_CSR_PROC2MNGR, rs1, `PROC_F3_CSRW, 5'd0, `PROC_OP_SYSTEM);
  endfunction

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic check_word(input logic [`PROC_XLEN-1:0] got,
                            input logic [`PROC_XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Data is compared for writes only
  task automatic check_mem_req(input proc_pkg::mem_req_t got, input proc_pkg::mem_req_t exp,
                               input string what);
    if (got.type_ !== exp.type_ || got.addr !== exp.addr ||
        (exp.type_ == `PROC_MEM_WRITE && got.data !== exp.data)) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got type %0d addr %h data %h expected type %0d addr %h data %h",
               $time, what, got.type_, got.addr, got.data, exp.type_, exp.addr, exp.data);
    end
  endtask

  // ------------------------------------------------
  // Program generation with expected results
  // ------------------------------------------------
  task automatic build_program();
    logic [31:0] a, b, base, data;
    logic [11:0] imm;
    proc_pkg::alu_op_t op;
    int n;
    for (int k = 0; k < 10; k++) begin
      a  = rand_bits(32);
      b  = rand_bits(32);
      op = proc_pkg::alu_op_t'(k % 5);
      src_q.push_back(a);
      src_q.push_back(b);
      prog.push_back(enc_csrr(5'd1));
      prog.push_back(enc_csrr(5'd2));
      prog.push_back(enc_rop(op, 5'd3, 5'd1, 5'd2));
      prog.push_back(enc_csrw(5'd3));
      exp_q.push_back(ref_alu(op, a, b));
    end
    for (int k = 0; k < 6; k++) begin
      a   = rand_bits(32);
      imm = 12'(rand_bits(12));
      imm[11] = k[0];
      src_q.push_back(a);
      prog.push_back(enc_csrr(5'd1));
      prog.push_back(enc_i(imm, 5'd1, `PROC_F3_ADD, 5'd3, `PROC_OP_IMM));
      prog.push_back(enc_csrw(5'd3));
      exp_q.push_back(ref_alu(proc_pkg::ALU_ADD, a, {{20{imm[11]}}, imm}));
    end
    for (int k = 0; k < 4; k++) begin
      base = 32'h900 + {22'd0, 8'(rand_bits(8)), 2'b00};
      data = rand_bits(32);
      imm  = {{2{k[0]}}, 8'(rand_bits(8)), 2'b00};
      src_q.push_back(base);
      src_q.push_back(data);
      prog.push_back(enc_csrr(5'd1));
      prog.push_back(enc_csrr(5'd2));
      prog.push_back(enc_sw(imm, 5'd2, 5'd1));
      prog.push_back(enc_i(imm, 5'd1, `PROC_F3_LW, 5'd4, `PROC_OP_LOAD));
      prog.push_back(enc_csrw(5'd4));
      exp_q.push_back(data);
      exp_dmem_q.push_back('{type_: `PROC_MEM_WRITE, opaque: 8'd0,
                             addr: base + {{20{imm[11]}}, imm}, len: 2'd0, data: data});
      exp_dmem_q.push_back('{type_: `PROC_MEM_READ, opaque: 8'd0,
                             addr: base + {{20{imm[11]}}, imm}, len: 2'd0, data: '0});
    end
    // Countdown loop, branch back over addi and csrw
    n = 3 + int'(rand_bits(2));
    src_q.push_back(n);
    src_q.push_back(32'hC0DE_0001);
    prog.push_back(enc_csrr(5'd5));
    prog.push_back(enc_i(12'hFFF, 5'd5, `PROC_F3_ADD, 5'd5, `PROC_OP_IMM));
    prog.push_back(enc_csrw(5'd5));
    prog.push_back(enc_bne(-13'sd8, 5'd5, 5'd0));
    prog.push_back(enc_csrr(5'd7));
    prog.push_back(enc_csrw(5'd7));
    for (int i = n - 1; i >= 0; i--) begin
      exp_q.push_back(i);
    end
    exp_q.push_back(32'hC0DE_0001);
  endtask

  // ------------------------------------------------
  // Memory and manager models
  // ------------------------------------------------
  always @(negedge clk) begin
    imem_req_rdy  = !imem_busy && (!stall_en || rand_bits(1) == 32'd1);
    imem_resp_val = imem_busy && imem_delay == 0;
    imem_resp_msg = '{type_: `PROC_MEM_READ, opaque: 8'd0, test: 2'd0, len: 2'd0,
                      data: mem[imem_addr[11:2]]};
    if (imem_busy && imem_delay > 0) imem_delay--;
    dmem_req_rdy  = !dmem_busy && (!stall_en || rand_bits(1) == 32'd1);
    dmem_resp_val = dmem_busy && dmem_delay == 0;
    dmem_resp_msg = '{type_: `PROC_MEM_READ, opaque: 8'd0, test: 2'd0, len: 2'd0,
                      data: dmem_data};
    if (dmem_busy && dmem_delay > 0) dmem_delay--;
    m2p_val = src_idx < src_q.size() && (!stall_en || rand_bits(1) == 32'd1);
    m2p_msg = (src_idx < src_q.size()) ? src_q[src_idx] : '0;
    p2m_rdy = !stall_en || rand_bits(1) == 32'd1;
  end

  // Handshakes seen at the rising edge, compare included
  always @(posedge clk) begin
    if (reset) begin
      imem_busy = 1'b0;
      dmem_busy = 1'b0;
    end else begin
      if (imem_resp_val && imem_resp_rdy) imem_busy = 1'b0;
      if (dmem_resp_val && dmem_resp_rdy) dmem_busy = 1'b0;
      if (imem_req_val && imem_req_rdy) begin
        if (!first_seen) begin
          check_mem_req(imem_req_msg, '{type_: `PROC_MEM_READ, opaque: 8'd0,
                        addr: `PROC_RESET_PC, len: 2'd0, data: '0}, "first fetch");
          first_seen = 1'b1;
        end
        imem_busy  = 1'b1;
        imem_addr  = imem_req_msg.addr;
        imem_delay = stall_en ? int'(rand_bits(2)) : 0;
      end
      if (dmem_req_val && dmem_req_rdy) begin
        if (dmem_idx < exp_dmem_q.size()) begin
          check_mem_req(dmem_req_msg, exp_dmem_q[dmem_idx], "dmem request");
        end else begin
          err_cnt++;
          $display("Unexpected extra dmem request at %0t", $time);
        end
        dmem_idx++;
        if (dmem_req_msg.type_ == `PROC_MEM_WRITE) begin
          mem[dmem_req_msg.addr[11:2]] = dmem_req_msg.data;
        end
        dmem_data  = mem[dmem_req_msg.addr[11:2]];
        dmem_busy  = 1'b1;
        dmem_delay = stall_en ? int'(rand_bits(2)) : 0;
      end
      if (m2p_val && m2p_rdy) src_idx++;
      if (p2m_val && p2m_rdy) begin
        if (out_idx < exp_q.size()) begin
          check_word(p2m_msg, exp_q[out_idx], "proc2mngr word");
        end else begin
          err_cnt++;
          $display("Unexpected extra proc2mngr word at %0t", $time);
        end
        if (run_id == 0) got0_q.push_back(p2m_msg);
        else got1_q.push_back(p2m_msg);
        out_idx++;
      end
    end
  end

  task automatic run_program(input logic stall);
    int cycles;
    stall_en = stall;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = '0;
    end
    foreach (prog[i]) mem[(`PROC_RESET_PC >> 2) + i] = prog[i];
    src_idx    = 0;
    out_idx    = 0;
    dmem_idx   = 0;
    first_seen = 1'b0;
    reset      = 1'b1;
    repeat (8) @(negedge clk);
    check_bit(imem_req_val, 1'b0, "imem_req_val in reset");
    check_bit(imem_resp_rdy, 1'b0, "imem_resp_rdy in reset");
    check_bit(dmem_req_val, 1'b0, "dmem_req_val in reset");
    check_bit(dmem_resp_rdy, 1'b0, "dmem_resp_rdy in reset");
    check_bit(m2p_rdy, 1'b0, "mngr2proc_rdy in reset");
    check_bit(p2m_val, 1'b0, "proc2mngr_val in reset");
    reset  = 1'b0;
    cycles = 0;
    while (out_idx < exp_q.size() && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (out_idx < exp_q.size()) begin
      timeout_cnt++;
      $display("Timeout: only %0d of %0d output words arrived", out_idx, exp_q.size());
    end
  endtask

  initial begin
    reset         = 1'b1;
    imem_req_rdy  = 1'b0;
    imem_resp_val = 1'b0;
    imem_resp_msg = '0;
    dmem_req_rdy  = 1'b0;
    dmem_resp_val = 1'b0;
    dmem_resp_msg = '0;
    m2p_val       = 1'b0;
    m2p_msg       = '0;
    p2m_rdy       = 1'b0;
    imem_busy     = 1'b0;
    dmem_busy     = 1'b0;
    imem_addr     = '0;
    dmem_data     = '0;
    src_idx       = 0;
    build_program();
    run_program(1'b0);
    if (timeout_cnt == 0) begin
      run_id = 1;
      run_program(1'b1);
      check_word(got1_q.size(), got0_q.size(), "stalled run word count");
      foreach (got1_q[i]) begin
        if (i < got0_q.size()) check_word(got1_q[i], got0_q[i], "stalled run word");
      end
    end
    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- hdl/proc_top.sv
// ------------------------------------------------
// Multicycle RV32I subset core, top level
// dmem requests and proc2mngr words leave through
// one-entry bypass queues
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_top (
  input  logic                  clk,
  input  logic                  reset,
  output proc_pkg::mem_req_t    imem_req_msg_o,
  output logic                  imem_req_val_o,
  input  logic                  imem_req_rdy_i,
  input  proc_pkg::mem_resp_t   imem_resp_msg_i,
  input  logic                  imem_resp_val_i,
  output logic                  imem_resp_rdy_o,
  output proc_pkg::mem_req_t    dmem_req_msg_o,
  output logic                  dmem_req_val_o,
  input  logic                  dmem_req_rdy_i,
  input  proc_pkg::mem_resp_t   dmem_resp_msg_i,
  input  logic                  dmem_resp_val_i,
  output logic                  dmem_resp_rdy_o,
  input  logic [`PROC_XLEN-1:0] mngr2proc_msg_i,
  input  logic                  mngr2proc_val_i,
  output logic                  mngr2proc_rdy_o,
  output logic [`PROC_XLEN-1:0] proc2mngr_msg_o,
  output logic                  proc2mngr_val_o,
  input  logic                  proc2mngr_rdy_i
);

  proc_pkg::dec_t        dec;
  proc_pkg::mem_req_t    dmem_enq_msg;
  logic                  dmem_enq_val, dmem_enq_rdy;
  logic [`PROC_XLEN-1:0] p2m_enq_msg;
  logic                  p2m_enq_val, p2m_enq_rdy;
  logic [`PROC_XLEN-1:0] inst, rs1_data, rs2_data, alu_result, mem_addr, wr_data;
  logic                  branch_taken, wr_en;
  logic [4:0]            wr_addr;

  proc_ctrl i_ctrl (
    .clk, .reset,
    .dec_i (dec), .alu_result_i (alu_result), .mem_addr_i (mem_addr),
    .branch_taken_i (branch_taken), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .inst_o (inst), .pc_o (),
    .wr_en_o (wr_en), .wr_addr_o (wr_addr), .wr_data_o (wr_data),
    .imem_req_msg_o, .imem_req_val_o, .imem_req_rdy_i,
    .imem_resp_msg_i, .imem_resp_val_i, .imem_resp_rdy_o,
    .dmem_enq_msg_o (dmem_enq_msg), .dmem_enq_val_o (dmem_enq_val),
    .dmem_enq_rdy_i (dmem_enq_rdy),
    .dmem_resp_msg_i, .dmem_resp_val_i, .dmem_resp_rdy_o,
    .mngr2proc_msg_i, .mngr2proc_val_i, .mngr2proc_rdy_o,
    .p2m_enq_msg_o (p2m_enq_msg), .p2m_enq_val_o (p2m_enq_val),
    .p2m_enq_rdy_i (p2m_enq_rdy)
  );

  proc_decode i_decode (.inst_i (inst), .dec_o (dec));

  proc_regfile i_regfile (
    .clk, .reset,
    .rs1_addr_i (dec.rs1), .rs2_addr_i (dec.rs2),
    .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
    .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data)
  );

  proc_exec i_exec (
    .dec_i (dec), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .alu_result_o (alu_result), .mem_addr_o (mem_addr), .branch_taken_o (branch_taken)
  );

  // ------------------------------------------------
  // Output queues
  // ------------------------------------------------
  proc_bypass_queue #(.T (proc_pkg::mem_req_t)) i_dmem_queue (
    .clk, .reset,
    .enq_msg_i (dmem_enq_msg), .enq_val_i (dmem_enq_val), .enq_rdy_o (dmem_enq_rdy),
    .deq_msg_o (dmem_req_msg_o), .deq_val_o (dmem_req_val_o), .deq_rdy_i (dmem_req_rdy_i)
  );

  proc_bypass_queue #(.T (logic [`PROC_XLEN-1:0])) i_p2m_queue (
    .clk, .reset,
    .enq_msg_i (p2m_enq_msg), .enq_val_i (p2m_enq_val), .enq_rdy_o (p2m_enq_rdy),
    .deq_msg_o (proc2mngr_msg_o), .deq_val_o (proc2mngr_val_o), .deq_rdy_i (proc2mngr_rdy_i)
  );

endmodule

//--- hdl/proc_ctrl.sv
// ------------------------------------------------
// Multicycle FSM: idle, fetch request, fetch wait,
// execute, memory wait. One instruction at a time,
// PC held in place under any back-pressure
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  proc_pkg::dec_t        dec_i,
  input  logic [`PROC_XLEN-1:0] alu_result_i,
  input  logic [`PROC_XLEN-1:0] mem_addr_i,
  input  logic                  branch_taken_i,
  input  logic [`PROC_XLEN-1:0] rs1_data_i,
  input  logic [`PROC_XLEN-1:0] rs2_data_i,
  output logic [`PROC_XLEN-1:0] inst_o,
  output logic [`PROC_XLEN-1:0] pc_o,
  output logic                  wr_en_o,
  output logic [4:0]            wr_addr_o,
  output logic [`PROC_XLEN-1:0] wr_data_o,
  output proc_pkg::mem_req_t    imem_req_msg_o,
  output logic                  imem_req_val_o,
  input  logic                  imem_req_rdy_i,
  input  proc_pkg::mem_resp_t   imem_resp_msg_i,
  input  logic                  imem_resp_val_i,
  output logic                  imem_resp_rdy_o,
  output proc_pkg::mem_req_t    dmem_enq_msg_o,
  output logic                  dmem_enq_val_o,
  input  logic                  dmem_enq_rdy_i,
  input  proc_pkg::mem_resp_t   dmem_resp_msg_i,
  input  logic                  dmem_resp_val_i,
  output logic                  dmem_resp_rdy_o,
  input  logic [`PROC_XLEN-1:0] mngr2proc_msg_i,
  input  logic                  mngr2proc_val_i,
  output logic                  mngr2proc_rdy_o,
  output logic [`PROC_XLEN-1:0] p2m_enq_msg_o,
  output logic                  p2m_enq_val_o,
  input  logic                  p2m_enq_rdy_i
);

  typedef enum logic [2:0] {S_IDLE, S_FREQ, S_FWAIT, S_EXEC, S_MWAIT} state_t;

  state_t                state_q, state_d;
  logic [`PROC_XLEN-1:0] pc_q, pc_d;
  logic [`PROC_XLEN-1:0] inst_q;

  // ------------------------------------------------
  // Outgoing messages
  // ------------------------------------------------
  assign imem_req_msg_o = '{type_: `PROC_MEM_READ, opaque: 8'd0, addr: pc_q,
                            len: 2'd0, data: '0};
  assign dmem_enq_msg_o = '{type_: dec_i.is_store ? `PROC_MEM_WRITE : `PROC_MEM_READ,
                            opaque: 8'd0, addr: mem_addr_i, len: 2'd0, data: rs2_data_i};
  assign p2m_enq_msg_o  = rs1_data_i;
  assign inst_o         = inst_q;
  assign pc_o           = pc_q;
  assign wr_addr_o      = dec_i.rd;

  // ------------------------------------------------
  // Next state, handshakes and writeback
  // ------------------------------------------------
  always_comb begin
    state_d         = state_q;
    pc_d            = pc_q;
    imem_req_val_o  = 1'b0;
    imem_resp_rdy_o = 1'b0;
    dmem_enq_val_o  = 1'b0;
    dmem_resp_rdy_o = 1'b0;
    mngr2proc_rdy_o = 1'b0;
    p2m_enq_val_o   = 1'b0;
    wr_en_o         = 1'b0;
    wr_data_o       = alu_result_i;
    case (state_q)
      S_IDLE: state_d = S_FREQ;
      S_FREQ: begin
        imem_req_val_o = 1'b1;
        if (imem_req_rdy_i) state_d = S_FWAIT;
      end
      S_FWAIT: begin
        imem_resp_rdy_o = 1'b1;
        if (imem_resp_val_i) state_d = S_EXEC;
      end
      S_EXEC: begin
        if (dec_i.is_csrr) begin
          mngr2proc_rdy_o = 1'b1;
          wr_data_o       = mngr2proc_msg_i;
          wr_en_o         = mngr2proc_val_i;
          if (mngr2proc_val_i) state_d = S_IDLE;
        end else if (dec_i.is_csrw) begin
          p2m_enq_val_o = 1'b1;
          if (p2m_enq_rdy_i) state_d = S_IDLE;
        end else if (dec_i.is_load || dec_i.is_store) begin
          dmem_enq_val_o = 1'b1;
          if (dmem_enq_rdy_i) state_d = S_MWAIT;
        end else begin
          // ALU ops, BNE and no-ops finish here
          wr_en_o = dec_i.reg_write;
          state_d = S_IDLE;
        end
        if (state_d != S_EXEC) begin
          pc_d = branch_taken_i ? pc_q + dec_i.imm : pc_q + 32'd4;
        end
      end
      S_MWAIT: begin
        dmem_resp_rdy_o = 1'b1;
        wr_data_o       = dmem_resp_msg_i.data;
        wr_en_o         = dmem_resp_val_i && dec_i.is_load;
        if (dmem_resp_val_i) state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
    wr_en_o = wr_en_o && (dec_i.rd != '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      pc_q    <= `PROC_RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (imem_resp_val_i && imem_resp_rdy_o) begin
      inst_q <= imem_resp_msg_i.data;
    end
  end

  a_fetch_only_in_freq: assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o |-> state_q == S_FREQ);

  // Fetch request held stable until the memory takes it
  a_fetch_held: assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o && !imem_req_rdy_i |=> imem_req_val_o && $stable(imem_req_msg_o));

  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wr_en_o |-> dec_i.rd != '0);

endmodule

//--- hdl/proc_bypass_queue.sv
// ------------------------------------------------
// One-entry bypass queue, valid/ready on both sides
// An enqueue into an empty queue is visible on the
// dequeue side in the same cycle
// ------------------------------------------------
`timescale 1ns/1ps

module proc_bypass_queue #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic reset,
  input  T     enq_msg_i,
  input  logic enq_val_i,
  output logic enq_rdy_o,
  output T     deq_msg_o,
  output logic deq_val_o,
  input  logic deq_rdy_i
);

  logic full_q;
  T     entry_q;

  assign enq_rdy_o = !full_q;
  assign deq_val_o = full_q || enq_val_i;
  assign deq_msg_o = full_q ? entry_q : enq_msg_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !deq_rdy_i;
    end else begin
      // Capture only when the bypass path was not taken
      full_q <= enq_val_i && !deq_rdy_i;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (!full_q && enq_val_i && !deq_rdy_i) begin
      entry_q <= enq_msg_i;
    end
  end

  // Stored word stays in place until it leaves
  a_no_enq_when_full: assert property (@(posedge clk) disable iff (reset)
    full_q && !deq_rdy_i |=> full_q && $stable(entry_q));

  // A stalled bypass word is held and offered again next cycle
  a_stalled_word_kept: assert property (@(posedge clk) disable iff (reset)
    enq_val_i && enq_rdy_o && !deq_rdy_i |=> deq_val_o && deq_msg_o == $past(enq_msg_i));

endmodule

//--- hdl/proc_exec.sv
// ------------------------------------------------
// ALU, address adder and BNE compare
// Pure combinational, no overflow detection
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_exec (
  input  proc_pkg::dec_t        dec_i,
  input  logic [`PROC_XLEN-1:0] rs1_data_i,
  input  logic [`PROC_XLEN-1:0] rs2_data_i,
  output logic [`PROC_XLEN-1:0] alu_result_o,
  output logic [`PROC_XLEN-1:0] mem_addr_o,
  output logic                  branch_taken_o
);

  logic [`PROC_XLEN-1:0] op_b;

  // ADDI takes the immediate, register ops take rs2
  assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

  always_comb begin
    case (dec_i.alu_op)
      proc_pkg::ALU_ADD: alu_result_o = rs1_data_i + op_b;
      proc_pkg::ALU_SUB: alu_result_o = rs1_data_i - op_b;
      proc_pkg::ALU_AND: alu_result_o = rs1_data_i & op_b;
      proc_pkg::ALU_OR:  alu_result_o = rs1_data_i | op_b;
      proc_pkg::ALU_XOR: alu_result_o = rs1_data_i ^ op_b;
      default:           alu_result_o = '0;
    endcase
  end

  assign mem_addr_o     = rs1_data_i + dec_i.imm;
  assign branch_taken_o = dec_i.is_bne && (rs1_data_i != rs2_data_i);

endmodule

//--- hdl/proc_regfile.sv
// ------------------------------------------------
// 2R1W register file, combinational reads
// x0 reads as zero and ignores writes
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [4:0]            rs1_addr_i,
  input  logic [4:0]            rs2_addr_i,
  output logic [`PROC_XLEN-1:0] rs1_data_o,
  output logic [`PROC_XLEN-1:0] rs2_data_o,
  input  logic                  wr_en_i,
  input  logic [4:0]            wr_addr_i,
  input  logic [`PROC_XLEN-1:0] wr_data_i
);

  logic [`PROC_XLEN-1:0] regs [`PROC_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `PROC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- hdl/proc_decode.sv
// ------------------------------------------------
// Instruction decoder for the kept subset
// Anything else, including other CSRs, is a no-op
// ------------------------------------------------
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_decode (
  input  logic [`PROC_XLEN-1:0] inst_i,
  output proc_pkg::dec_t        dec_o
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`PROC_XLEN-1:0] imm_i;
  logic [`PROC_XLEN-1:0] imm_s;
  logic [`PROC_XLEN-1:0] imm_b;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    dec_o        = '0;
    dec_o.rd     = inst_i[11:7];
    dec_o.rs1    = inst_i[19:15];
    dec_o.rs2    = inst_i[24:20];
    dec_o.csr    = inst_i[31:20];
    dec_o.alu_op = proc_pkg::ALU_ADD;
    case (opcode)
      `PROC_OP_REG: begin
        // SUB is the only kept op with a nonzero funct7
        if (funct7 == `PROC_F7_BASE ||
            (funct7 == `PROC_F7_SUB && funct3 == `PROC_F3_ADD)) begin
          dec_o.reg_write = 1'b1;
          case (funct3)
            `PROC_F3_ADD: dec_o.alu_op = funct7[5] ? proc_pkg::ALU_SUB : proc_pkg::ALU_ADD;
            `PROC_F3_XOR: dec_o.alu_op = proc_pkg::ALU_XOR;
            `PROC_F3_OR:  dec_o.alu_op = proc_pkg::ALU_OR;
            `PROC_F3_AND: dec_o.alu_op = proc_pkg::ALU_AND;
            default:      dec_o.reg_write = 1'b0;
          endcase
        end
      end
      `PROC_OP_IMM: begin
        if (funct3 == `PROC_F3_ADD) begin
          dec_o.use_imm   = 1'b1;
          dec_o.reg_write = 1'b1;
          dec_o.imm       = imm_i;
        end
      end
      `PROC_OP_LOAD: begin
        dec_o.is_load   = (funct3 == `PROC_F3_LW);
        dec_o.reg_write = (funct3 == `PROC_F3_LW);
        dec_o.imm       = imm_i;
      end
      `PROC_OP_STORE: begin
        dec_o.is_store = (funct3 == `PROC_F3_SW);
        dec_o.imm      = imm_s;
      end
      `PROC_OP_BRANCH: begin
        dec_o.is_bne = (funct3 == `PROC_F3_BNE);
        dec_o.imm    = imm_b;
      end
      `PROC_OP_SYSTEM: begin
        dec_o.is_csrr = (funct3 == `PROC_F3_CSRR) && (dec_o.csr == `PROC_CSR_MNGR2PROC);
        dec_o.is_csrw = (funct3 == `PROC_F3_CSRW) && (dec_o.csr == `PROC_CSR_PROC2MNGR);
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/proc_pkg.sv
// ------------------------------------------------
// Shared types of the multicycle core
// Memory messages are fixed at 4-byte accesses
// ------------------------------------------------
`include "proc_macros.svh"

package proc_pkg;

  // ------------------------------------------------
  // Memory messages
  // ------------------------------------------------
  typedef struct packed {
    logic [2:0]            type_;
    logic [7:0]            opaque;
    logic [`PROC_XLEN-1:0] addr;
    logic [1:0]            len;
    logic [`PROC_XLEN-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [2:0]            type_;
    logic [7:0]            opaque;
    logic [1:0]            test;
    logic [1:0]            len;
    logic [`PROC_XLEN-1:0] data;
  } mem_resp_t;

  // ------------------------------------------------
  // Decoded instruction
  // ------------------------------------------------
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  // All flags low means the word runs as a no-op
  typedef struct packed {
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    alu_op_t               alu_op;
    logic                  use_imm;
    logic                  reg_write;
    logic                  is_load;
    logic                  is_store;
    logic                  is_bne;
    logic                  is_csrr;
    logic                  is_csrw;
    logic [`PROC_XLEN-1:0] imm;
    logic [11:0]           csr;
  } dec_t;

endpackage

//--- include/proc_macros.svh
// ------------------------------------------------
// Word width, reset PC, memory message codes and
// the encodings of the kept RV32I subset only
// ------------------------------------------------
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

`define PROC_XLEN      32
`define PROC_NREGS     32
`define PROC_RESET_PC  32'h0000_0200

// Memory message type codes
`define PROC_MEM_READ   3'd0
`define PROC_MEM_WRITE  3'd1

// Opcodes
`define PROC_OP_REG     7'b0110011
`define PROC_OP_IMM     7'b0010011
`define PROC_OP_LOAD    7'b0000011
`define PROC_OP_STORE   7'b0100011
`define PROC_OP_BRANCH  7'b1100011
`define PROC_OP_SYSTEM  7'b1110011

// Funct3 and funct7 fields
`define PROC_F3_ADD     3'b000
`define PROC_F3_XOR     3'b100
`define PROC_F3_OR      3'b110
`define PROC_F3_AND     3'b111
`define PROC_F3_LW      3'b010
`define PROC_F3_SW      3'b010
`define PROC_F3_BNE     3'b001
`define PROC_F3_CSRR    3'b010
`define PROC_F3_CSRW    3'b001
`define PROC_F7_BASE    7'b0000000
`define PROC_F7_SUB     7'b0100000

// Manager CSRs
`define PROC_CSR_MNGR2PROC  12'hFC0
`define PROC_CSR_PROC2MNGR  12'h7C0

`endif
